// ==== common/marble_params.svh ====
/* Frame size limits, inter-frame gap length and buffer address width */

`ifndef MARBLE_PARAMS_SVH
`define MARBLE_PARAMS_SVH

// Largest accepted frame, destination address through FCS
`define MAX_FRAME 1518

// Smallest accepted frame including FCS
`define MIN_FRAME 64

// Idle cycles after each transmitted frame
`define IFG_BYTES 12

// One-frame buffer address width, 2 KB
`define BUF_AW 11

`endif

// ==== common/marble_pkg.sv ====
/* Shared types for the echo path: byte stream, frame descriptor, FSM states, CRC-32 step */
`default_nettype none

`include "marble_params.svh"

package marble_pkg;

	typedef struct packed {
		logic [7:0] data;
		logic valid;
		logic last;
	} byte_stream_t;

	// Stored frame length, FCS not included
	typedef struct packed {
		logic [`BUF_AW-1:0] len;
	} frame_desc_t;

	typedef enum logic [1:0] {RX_IDLE, RX_PREAMBLE, RX_DATA, RX_DROP} rx_state_t;

	typedef enum logic [2:0] {TX_IDLE, TX_PREAMBLE, TX_SFD, TX_PAYLOAD, TX_FCS, TX_GAP} tx_state_t;

	// Reflected IEEE 802.3 polynomial
	localparam logic [31:0] CRC_POLY = 32'hedb88320;
	// Register value after running over data plus a good FCS
	localparam logic [31:0] CRC_RESIDUE = 32'hdebb20e3;

	function automatic logic [31:0] crc32_next(input logic [31:0] crc, input logic [7:0] data);
		logic [31:0] c;
		c = crc ^ {24'h000000, data};
		for (int i = 0; i < 8; i++) begin
			c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
		end
		return c;
	endfunction

endpackage

`default_nettype wire

// ==== hw/gmii_rx/gmii_rx_stage.sv ====
/* GMII receive stage: preamble and SFD detection, FCS and length checks,
   buffer write port and commit handshake */
`timescale 1ns/100ps
`default_nettype none

`include "marble_params.svh"

module gmii_rx_stage (
	input logic tx_clk,
	input logic rst_n,
	input logic [7:0] gmii_rxd,
	input logic gmii_rx_dv,
	input logic gmii_rx_er,
	output logic wr_en,
	output logic [`BUF_AW-1:0] wr_addr,
	output logic [7:0] wr_data,
	output marble_pkg::frame_desc_t commit_desc,
	output logic commit_req,
	input logic commit_ack,
	output logic frame_dropped
);
	import marble_pkg::*;

	rx_state_t state;
	logic [31:0] crc;
	logic [`BUF_AW-1:0] count;
	logic rx_err;
	logic busy;
	logic frame_ok;

	// Evaluated in the first cycle with gmii_rx_dv low
	assign frame_ok = (crc == CRC_RESIDUE) && (count >= `MIN_FRAME) &&
		(count <= `MAX_FRAME) && !rx_err && !busy && !commit_req;

	always_ff @(posedge tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= RX_IDLE;
			crc <= '1;
			count <= '0;
			rx_err <= 1'b0;
			busy <= 1'b0;
			wr_en <= 1'b0;
			commit_req <= 1'b0;
			frame_dropped <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			frame_dropped <= 1'b0;
			if (commit_ack) begin
				commit_req <= 1'b0;
			end
			case (state)
				RX_IDLE: begin
					if (gmii_rx_dv) begin
						state <= (gmii_rxd == 8'h55) ? RX_PREAMBLE : RX_DROP;
					end
				end
				RX_PREAMBLE: begin
					if (!gmii_rx_dv) begin
						state <= RX_IDLE;
					end else if (gmii_rxd == 8'hd5) begin
						state <= RX_DATA;
						crc <= '1;
						count <= '0;
						rx_err <= 1'b0;
						// Buffer still holds or is taking a frame
						busy <= commit_req | commit_ack;
					end else if (gmii_rxd != 8'h55) begin
						state <= RX_DROP;
					end
				end
				RX_DATA: begin
					if (gmii_rx_dv) begin
						crc <= crc32_next(crc, gmii_rxd);
						// Saturate so oversize frames stay detectable
						if (~&count) begin
							count <= count + 1'b1;
						end
						if (gmii_rx_er) begin
							rx_err <= 1'b1;
						end
						wr_en <= !busy && (count < `MAX_FRAME);
					end else begin
						state <= RX_IDLE;
						if (frame_ok) begin
							commit_req <= 1'b1;
						end else begin
							frame_dropped <= 1'b1;
						end
					end
				end
				RX_DROP: begin
					if (!gmii_rx_dv) begin
						state <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// Write data path and descriptor
	always_ff @(posedge tx_clk) begin
		wr_addr <= count;
		wr_data <= gmii_rxd;
		if (state == RX_DATA && !gmii_rx_dv) begin
			commit_desc.len <= count - 4'd4;
		end
	end

endmodule

`default_nettype wire

// ==== hw/frame_buffer.sv ====
/* One-frame byte RAM with descriptor register, commit and send handshakes */
`timescale 1ns/100ps
`default_nettype none

`include "marble_params.svh"

module frame_buffer (
	input logic tx_clk,
	input logic rst_n,
	input logic wr_en,
	input logic [`BUF_AW-1:0] wr_addr,
	input logic [7:0] wr_data,
	input marble_pkg::frame_desc_t commit_desc,
	input logic commit_req,
	output logic commit_ack,
	output marble_pkg::frame_desc_t send_desc,
	output logic send_req,
	input logic send_ack,
	input logic [`BUF_AW-1:0] rd_addr,
	output marble_pkg::byte_stream_t rd_stream
);
	import marble_pkg::*;

	logic [7:0] mem [0:(1 << `BUF_AW)-1];
	frame_desc_t desc;
	logic full;
	logic take;
	logic [7:0] rd_data;
	logic rd_last;
	logic rd_valid;

	// Accept a commit only while empty
	assign take = commit_req && !commit_ack && !full;

	always_ff @(posedge tx_clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Registered read port
	always_ff @(posedge tx_clk) begin
		rd_data <= mem[rd_addr];
		rd_last <= (rd_addr == desc.len - 1'b1);
	end

	always_ff @(posedge tx_clk) begin
		if (take) begin
			desc <= commit_desc;
		end
	end

	always_ff @(posedge tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			full <= 1'b0;
			commit_ack <= 1'b0;
			send_req <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= full;
			// commit_ack held while the frame is stored
			if (take) begin
				full <= 1'b1;
				commit_ack <= 1'b1;
			end else if (commit_ack && !commit_req && !full) begin
				commit_ack <= 1'b0;
			end
			if (send_req && send_ack) begin
				send_req <= 1'b0;
				full <= 1'b0;
			end else if (full && !send_ack) begin
				send_req <= 1'b1;
			end
		end
	end

	assign send_desc = desc;
	assign rd_stream = '{data: rd_data, valid: rd_valid, last: rd_last};

endmodule

`default_nettype wire

// ==== hw/gmii_tx/gmii_tx_stage.sv ====
/* GMII transmit stage: preamble and SFD, payload with MAC swap, new FCS, inter-frame gap */
`timescale 1ns/100ps
`default_nettype none

`include "marble_params.svh"

module gmii_tx_stage (
	input logic tx_clk,
	input logic rst_n,
	input marble_pkg::frame_desc_t send_desc,
	input logic send_req,
	output logic send_ack,
	output logic [`BUF_AW-1:0] rd_addr,
	input marble_pkg::byte_stream_t rd_stream,
	output logic [7:0] gmii_txd,
	output logic gmii_tx_en,
	output logic gmii_tx_er,
	output logic frame_echoed
);
	import marble_pkg::*;

	localparam logic [`BUF_AW-1:0] MAC_BYTES = 6;
	localparam logic [`BUF_AW-1:0] MAC_END = 12;

	tx_state_t state;
	// Shared by preamble, FCS and gap
	logic [3:0] cnt;
	logic [`BUF_AW-1:0] fidx;
	logic [31:0] crc;

	// Bytes 0-5 and 6-11 trade places
	function automatic logic [`BUF_AW-1:0] swap_addr(input logic [`BUF_AW-1:0] idx);
		if (idx < MAC_BYTES) begin
			return idx + MAC_BYTES;
		end else if (idx < MAC_END) begin
			return idx - MAC_BYTES;
		end
		return idx;
	endfunction

	assign rd_addr = swap_addr(fidx);

	always_ff @(posedge tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= TX_IDLE;
			cnt <= '0;
			fidx <= '0;
			crc <= '1;
			send_ack <= 1'b0;
			gmii_txd <= 8'h00;
			gmii_tx_en <= 1'b0;
			gmii_tx_er <= 1'b0;
			frame_echoed <= 1'b0;
		end else begin
			gmii_tx_er <= 1'b0;
			frame_echoed <= 1'b0;
			if (send_ack && !send_req) begin
				send_ack <= 1'b0;
			end
			case (state)
				TX_IDLE: begin
					gmii_tx_en <= 1'b0;
					gmii_txd <= 8'h00;
					if (send_req && !send_ack && rd_stream.valid) begin
						state <= TX_PREAMBLE;
						gmii_tx_en <= 1'b1;
						gmii_txd <= 8'h55;
						cnt <= 4'd1;
						fidx <= '0;
						crc <= '1;
					end
				end
				TX_PREAMBLE: begin
					// Byte 0 is fetched during these cycles
					gmii_txd <= 8'h55;
					cnt <= cnt + 1'b1;
					if (cnt == 4'd6) begin
						state <= TX_SFD;
					end
				end
				TX_SFD: begin
					gmii_txd <= 8'hd5;
					state <= TX_PAYLOAD;
				end
				TX_PAYLOAD: begin
					gmii_txd <= rd_stream.data;
					crc <= crc32_next(crc, rd_stream.data);
					if (rd_stream.last) begin
						state <= TX_FCS;
						cnt <= '0;
						send_ack <= 1'b1;
					end
				end
				TX_FCS: begin
					// Inverted CRC, least significant byte first
					gmii_txd <= ~crc[7:0];
					crc <= {8'h00, crc[31:8]};
					cnt <= cnt + 1'b1;
					if (cnt == 4'd3) begin
						state <= TX_GAP;
						cnt <= '0;
					end
				end
				TX_GAP: begin
					gmii_tx_en <= 1'b0;
					gmii_txd <= 8'h00;
					cnt <= cnt + 1'b1;
					if (cnt == `IFG_BYTES - 1) begin
						state <= TX_IDLE;
						frame_echoed <= 1'b1;
					end
				end
				default: state <= TX_IDLE;
			endcase
			// Fetch index runs one byte ahead, parks on the last byte
			if ((state == TX_SFD || state == TX_PAYLOAD) &&
				(fidx != send_desc.len - 1'b1)) begin
				fidx <= fidx + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/frame_stats.sv ====
/* Echoed and dropped frame counters shown on the LEDs */
`timescale 1ns/100ps
`default_nettype none

module frame_stats (
	input logic tx_clk,
	input logic rst_n,
	input logic frame_echoed,
	input logic frame_dropped,
	output logic [7:0] led
);

	logic [3:0] echo_cnt;
	logic [3:0] drop_cnt;

	// Both counters wrap at 16
	always_ff @(posedge tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			echo_cnt <= 4'd0;
			drop_cnt <= 4'd0;
		end else begin
			if (frame_echoed) begin
				echo_cnt <= echo_cnt + 1'b1;
			end
			if (frame_dropped) begin
				drop_cnt <= drop_cnt + 1'b1;
			end
		end
	end

	// Upper nibble drops, lower nibble echoes
	assign led = {drop_cnt, echo_cnt};

endmodule

`default_nettype wire

// ==== hw/marble_echo_top.sv ====
/* Ethernet echo top: receive stage, frame buffer, transmit stage and LED statistics */
`timescale 1ns/100ps
`default_nettype none

`include "marble_params.svh"

module marble_echo_top (
	input logic tx_clk,
	input logic rst_n,
	// GMII receive, assumed on tx_clk
	input logic [7:0] gmii_rxd,
	input logic gmii_rx_dv,
	input logic gmii_rx_er,
	// GMII transmit
	output logic [7:0] gmii_txd,
	output logic gmii_tx_en,
	output logic gmii_tx_er,
	output logic [7:0] led
);
	import marble_pkg::*;

	logic wr_en;
	logic [`BUF_AW-1:0] wr_addr;
	logic [7:0] wr_data;
	frame_desc_t commit_desc;
	logic commit_req;
	logic commit_ack;
	frame_desc_t send_desc;
	logic send_req;
	logic send_ack;
	logic [`BUF_AW-1:0] rd_addr;
	byte_stream_t rd_stream;
	logic frame_echoed;
	logic frame_dropped;

	gmii_rx_stage rx (
		.tx_clk(tx_clk), .rst_n(rst_n),
		.gmii_rxd(gmii_rxd), .gmii_rx_dv(gmii_rx_dv), .gmii_rx_er(gmii_rx_er),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.commit_desc(commit_desc), .commit_req(commit_req), .commit_ack(commit_ack),
		.frame_dropped(frame_dropped)
	);

	frame_buffer buffer (
		.tx_clk(tx_clk), .rst_n(rst_n),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.commit_desc(commit_desc), .commit_req(commit_req), .commit_ack(commit_ack),
		.send_desc(send_desc), .send_req(send_req), .send_ack(send_ack),
		.rd_addr(rd_addr), .rd_stream(rd_stream)
	);

	gmii_tx_stage tx (
		.tx_clk(tx_clk), .rst_n(rst_n),
		.send_desc(send_desc), .send_req(send_req), .send_ack(send_ack),
		.rd_addr(rd_addr), .rd_stream(rd_stream),
		.gmii_txd(gmii_txd), .gmii_tx_en(gmii_tx_en), .gmii_tx_er(gmii_tx_er),
		.frame_echoed(frame_echoed)
	);

	frame_stats stats (
		.tx_clk(tx_clk), .rst_n(rst_n),
		.frame_echoed(frame_echoed), .frame_dropped(frame_dropped),
		.led(led)
	);

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
/* Testbench clock and reset source */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD = 8,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2) clk = ~clk;
		end
	end

	// Release just after an edge, like the rest of the stimulus
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== verif/marble_echo_assert.sv ====
/* Concurrent checks on the GMII transmit port and the two frame handshakes */
`timescale 1ns/100ps
`default_nettype none

`include "marble_params.svh"

module marble_echo_assert (
	input logic tx_clk,
	input logic rst_n,
	input logic gmii_tx_en,
	input logic gmii_tx_er,
	input logic commit_req,
	input logic commit_ack,
	input logic send_req,
	input logic send_ack
);

	int fail_count = 0;

	task automatic flag_failure(input string what);
		$error("%s", what);
		fail_count++;
	endtask

	tx_er_low: assert property (@(posedge tx_clk) disable iff (!rst_n) !gmii_tx_er)
		else flag_failure("gmii_tx_er went high");

	// Idle time after every burst
	tx_gap: assert property (@(posedge tx_clk) disable iff (!rst_n)
		$fell(gmii_tx_en) |-> !gmii_tx_en [*`IFG_BYTES])
		else flag_failure("inter-frame gap on gmii_tx_en too short");

	commit_req_fall: assert property (@(posedge tx_clk) disable iff (!rst_n)
		$fell(commit_req) |-> $past(commit_ack))
		else flag_failure("commit_req fell before commit_ack rose");

	commit_ack_fall: assert property (@(posedge tx_clk) disable iff (!rst_n)
		$fell(commit_ack) |-> !$past(commit_req))
		else flag_failure("commit_ack fell while commit_req was high");

	send_req_fall: assert property (@(posedge tx_clk) disable iff (!rst_n)
		$fell(send_req) |-> $past(send_ack))
		else flag_failure("send_req fell before send_ack rose");

	send_ack_fall: assert property (@(posedge tx_clk) disable iff (!rst_n)
		$fell(send_ack) |-> !$past(send_req))
		else flag_failure("send_ack fell while send_req was high");

	tx_en_in_reset: assert property (@(posedge tx_clk) !rst_n |-> !gmii_tx_en)
		else flag_failure("gmii_tx_en high during reset");

endmodule

`default_nettype wire

// ==== verif/marble_echo_tb.sv ====
/* Echo testbench: random GMII frames, reference echo model, burst comparison
   and watchdog */
`timescale 1ns/100ps
`default_nettype none

`include "marble_params.svh"

module marble_echo_tb;
	import marble_pkg::*;

	typedef logic [7:0] byte_q_t [$];

	logic tx_clk;
	logic rst_n;
	logic [7:0] gmii_rxd;
	logic gmii_rx_dv;
	logic gmii_rx_er;
	logic [7:0] gmii_txd;
	logic gmii_tx_en;
	logic gmii_tx_er;
	logic [7:0] led;

	integer seed = 32'h15d01251;
	int cycle = 0;
	int dv_fall_cycle = 0;
	int echo_deadline = 0;
	int bursts_queued = 0;
	int bursts_done = 0;
	int exp_echoed = 0;
	int exp_dropped = 0;
	bit in_burst = 1'b0;
	logic [7:0] exp_bytes [$];
	int exp_lens [$];
	int exp_starts [$];

	tb_clock_gen clocks (.clk(tx_clk), .rst_n(rst_n));

	marble_echo_top dut_i (
		.tx_clk(tx_clk), .rst_n(rst_n),
		.gmii_rxd(gmii_rxd), .gmii_rx_dv(gmii_rx_dv), .gmii_rx_er(gmii_rx_er),
		.gmii_txd(gmii_txd), .gmii_tx_en(gmii_tx_en), .gmii_tx_er(gmii_tx_er),
		.led(led)
	);

	bind marble_echo_top marble_echo_assert checks (
		.tx_clk(tx_clk), .rst_n(rst_n),
		.gmii_tx_en(gmii_tx_en), .gmii_tx_er(gmii_tx_er),
		.commit_req(commit_req), .commit_ack(commit_ack),
		.send_req(send_req), .send_ack(send_ack)
	);

	always @(posedge tx_clk) begin
		cycle <= cycle + 1;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			fail_run($sformatf("ERROR: %s expected 0x%0h, actual 0x%0h", name, expected, actual));
		end
	endtask

	function automatic int random_len();
		return `MIN_FRAME + ($unsigned($random(seed)) % (`MAX_FRAME - `MIN_FRAME + 1));
	endfunction

	// Random bytes, then a valid FCS, low byte first
	function automatic byte_q_t make_frame(input int len);
		byte_q_t f;
		logic [31:0] crc;
		crc = '1;
		for (int i = 0; i < len - 4; i++) begin
			f.push_back(8'($random(seed)));
			crc = crc32_next(crc, f[i]);
		end
		crc = ~crc;
		for (int i = 0; i < 4; i++) begin
			f.push_back(crc[8*i +: 8]);
		end
		return f;
	endfunction

	// Preamble, SFD, addresses exchanged, FCS over the new byte order
	function automatic byte_q_t expected_echo(input byte_q_t frame);
		byte_q_t e;
		byte_q_t body;
		logic [31:0] crc;
		for (int i = 0; i < frame.size() - 4; i++) begin
			body.push_back(frame[i]);
		end
		for (int i = 0; i < 6; i++) begin
			body[i] = frame[i + 6];
			body[i + 6] = frame[i];
		end
		for (int i = 0; i < 7; i++) begin
			e.push_back(8'h55);
		end
		e.push_back(8'hd5);
		crc = '1;
		foreach (body[i]) begin
			e.push_back(body[i]);
			crc = crc32_next(crc, body[i]);
		end
		crc = ~crc;
		for (int i = 0; i < 4; i++) begin
			e.push_back(crc[8*i +: 8]);
		end
		return e;
	endfunction

	task automatic drive_byte(input logic [7:0] data, input logic dv, input logic er);
		@(posedge tx_clk);
		#1;
		gmii_rxd = data;
		gmii_rx_dv = dv;
		gmii_rx_er = er;
	endtask

	// err_idx of -1 means no receive error
	task automatic send_frame(input byte_q_t frame, input int err_idx);
		for (int i = 0; i < 7; i++) begin
			drive_byte(8'h55, 1'b1, 1'b0);
		end
		drive_byte(8'hd5, 1'b1, 1'b0);
		foreach (frame[i]) begin
			drive_byte(frame[i], 1'b1, i == err_idx);
		end
		drive_byte(8'h00, 1'b0, 1'b0);
		dv_fall_cycle = cycle;
	endtask

	task automatic expect_echo(input byte_q_t frame);
		byte_q_t echo;
		echo = expected_echo(frame);
		foreach (echo[i]) begin
			exp_bytes.push_back(echo[i]);
		end
		exp_lens.push_back(echo.size());
		exp_starts.push_back(dv_fall_cycle + 4);
		echo_deadline = cycle + frame.size() + 100;
		bursts_queued++;
		exp_echoed++;
	endtask

	task automatic wait_echo_done();
		wait (bursts_done == bursts_queued);
		// Gap, then the echo counter settles
		repeat (`IFG_BYTES + 4) @(negedge tx_clk);
		check_value("led", {exp_dropped[3:0], exp_echoed[3:0]}, led);
	endtask

	task automatic echo_frame(input int len);
		byte_q_t f;
		f = make_frame(len);
		send_frame(f, -1);
		expect_echo(f);
		wait_echo_done();
	endtask

	task automatic drop_frame(input byte_q_t frame, input int err_idx);
		send_frame(frame, err_idx);
		exp_dropped++;
		// Well past the echo latency
		repeat (`IFG_BYTES + 8) @(negedge tx_clk);
		check_value("led", {exp_dropped[3:0], exp_echoed[3:0]}, led);
	endtask

	// Every gmii_tx_en burst against the head of the expected queue
	initial begin : compare
		int burst_len;
		int burst_pos;
		burst_len = 0;
		burst_pos = 0;
		forever begin
			@(negedge tx_clk);
			if (gmii_tx_en === 1'b1) begin
				if (!in_burst && exp_lens.size() == 0) begin
					fail_run("gmii_tx_en burst appeared with no echo expected");
				end else if (!in_burst) begin
					in_burst = 1'b1;
					burst_pos = 0;
					burst_len = exp_lens.pop_front();
					check_value("gmii_tx_en rise cycle", exp_starts.pop_front(), cycle);
				end
				if (burst_pos >= burst_len) begin
					fail_run("gmii_tx_en burst is longer than the expected echo");
				end else begin
					check_value("gmii_txd", exp_bytes.pop_front(), gmii_txd);
					check_value("gmii_tx_er", 0, gmii_tx_er);
					burst_pos++;
				end
			end else if (in_burst) begin
				in_burst = 1'b0;
				check_value("gmii_tx_en burst length", burst_len, burst_pos);
				bursts_done++;
			end
		end
	end

	// Each pending echo gets its frame length plus 100 cycles
	initial begin : watchdog
		while (!(bursts_done < bursts_queued && cycle > echo_deadline)) begin
			@(negedge tx_clk);
		end
		fail_run("timeout: no echo appeared on gmii_tx_en");
	end

	initial begin : assertion_watch
		wait (dut_i.checks.fail_count != 0);
		fail_run("a concurrent assertion on the DUT failed");
	end

	initial begin : stimulus
		byte_q_t f;
		gmii_rxd = 8'h00;
		gmii_rx_dv = 1'b0;
		gmii_rx_er = 1'b0;
		@(posedge rst_n);
		repeat (4) @(negedge tx_clk);
		check_value("led", 0, led);
		check_value("gmii_tx_en", 0, gmii_tx_en);

		echo_frame(random_len());

		// Bad FCS, receive error, runt, oversize
		f = make_frame(random_len());
		f[f.size() - 1] ^= 8'h01;
		drop_frame(f, -1);
		drop_frame(make_frame(random_len()), 20);
		drop_frame(make_frame(60), -1);
		drop_frame(make_frame(`MAX_FRAME + 4), -1);

		// Second frame lands while the first is still held
		f = make_frame(random_len());
		send_frame(f, -1);
		expect_echo(f);
		repeat (`IFG_BYTES) drive_byte(8'h00, 1'b0, 1'b0);
		send_frame(make_frame(random_len()), -1);
		exp_dropped++;
		wait_echo_done();
		echo_frame(random_len());

		for (int i = 0; i < 20; i++) begin
			echo_frame(random_len());
		end

		if (dut_i.checks.fail_count == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			fail_run("assertion failures were reported");
		end
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+common
common/marble_pkg.sv
hw/gmii_rx/gmii_rx_stage.sv
hw/frame_buffer.sv
hw/gmii_tx/gmii_tx_stage.sv
hw/frame_stats.sv
hw/marble_echo_top.sv
verif/tb_clock_gen.sv
verif/marble_echo_assert.sv
verif/marble_echo_tb.sv

// ==== Bender.yml ====
package:
  name: marble_echo

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/marble_pkg.sv
      - hw/gmii_rx/gmii_rx_stage.sv
      - hw/frame_buffer.sv
      - hw/gmii_tx/gmii_tx_stage.sv
      - hw/frame_stats.sv
      - hw/marble_echo_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/tb_clock_gen.sv
      - verif/marble_echo_assert.sv
      - verif/marble_echo_tb.sv
